// ==== common/pipe_pkg.sv ====
// pipeline package
// widths, instruction encodings, ALU op codes, status codes and the instruction word

package pipe_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int XLEN      = 32;  // data and pc width
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 32;

	localparam logic [REG_IDX_W-1:0] ZERO_REG = '0;  // x0

	////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct3, shared by register and immediate forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [6:0] F7_SUB = 7'b0100000;  // only non-zero funct7 we take

	localparam logic [XLEN-1:0] INST_WFI = 32'h1050_0073;

	////////////////////////////////////////
	// ALU ops and status
	////////////////////////////////////////

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_SLT = 3'd2;  // signed compare
	localparam logic [2:0] ALU_XOR = 3'd3;
	localparam logic [2:0] ALU_OR  = 3'd4;
	localparam logic [2:0] ALU_AND = 3'd5;

	localparam logic [1:0] ERR_NONE    = 2'd0;
	localparam logic [1:0] ERR_ILLEGAL = 2'd1;
	localparam logic [1:0] ERR_HALTED  = 2'd2;

	// one instruction word, seen as R-type or I-type fields
	typedef union packed {
		struct packed {
			logic [6:0]           funct7;
			logic [REG_IDX_W-1:0] rs2;
			logic [REG_IDX_W-1:0] rs1;
			logic [2:0]           funct3;
			logic [REG_IDX_W-1:0] rd;
			logic [6:0]           opcode;
		} r;
		struct packed {
			logic [11:0]          imm;     // sign bit at 11
			logic [REG_IDX_W-1:0] rs1;
			logic [2:0]           funct3;
			logic [REG_IDX_W-1:0] rd;
			logic [6:0]           opcode;
		} i;
	} inst_word_t;

endpackage

// ==== design/decode/reg_file.sv ====
// register file
// 32 registers, x0 fixed at zero, reads see a same-cycle write

`timescale 1ns/1ps

module reg_file (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [pipe_pkg::REG_IDX_W-1:0] rs1_idx,
	input  logic [pipe_pkg::REG_IDX_W-1:0] rs2_idx,
	input  logic                           wr_en,
	input  logic [pipe_pkg::REG_IDX_W-1:0] wr_idx,
	input  logic [pipe_pkg::XLEN-1:0]      wr_data,
	output logic [pipe_pkg::XLEN-1:0]      rs1_data,
	output logic [pipe_pkg::XLEN-1:0]      rs2_data
);

	logic [pipe_pkg::XLEN-1:0] regs [pipe_pkg::NUM_REGS];
	logic                      wr_live;  // write that actually lands

	assign wr_live = wr_en && (wr_idx != pipe_pkg::ZERO_REG);

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int n = 0; n < pipe_pkg::NUM_REGS; n++)
				regs[n] <= '0;
		end else if (wr_live) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// write-through read ports
	always_comb begin
		if (rs1_idx == pipe_pkg::ZERO_REG)
			rs1_data = '0;
		else if (wr_live && wr_idx == rs1_idx)
			rs1_data = wr_data;
		else
			rs1_data = regs[rs1_idx];

		if (rs2_idx == pipe_pkg::ZERO_REG)
			rs2_data = '0;
		else if (wr_live && wr_idx == rs2_idx)
			rs2_data = wr_data;
		else
			rs2_data = regs[rs2_idx];
	end

endmodule

// ==== design/decode/decode_stage.sv ====
// decode stage
// accepts instructions, decodes them, reads the register file and locks on halt

`timescale 1ns/1ps

module decode_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           inst_valid,
	input  logic [pipe_pkg::XLEN-1:0]      inst,
	input  logic [pipe_pkg::XLEN-1:0]      inst_pc,
	input  logic                           wr_en,
	input  logic [pipe_pkg::REG_IDX_W-1:0] wr_idx,
	input  logic [pipe_pkg::XLEN-1:0]      wr_data,
	output logic                           inst_ready,
	output logic                           dec_valid,
	output logic [pipe_pkg::XLEN-1:0]      dec_pc,
	output logic [2:0]                     alu_op,
	output logic                           use_imm,
	output logic [pipe_pkg::XLEN-1:0]      imm,
	output logic [pipe_pkg::REG_IDX_W-1:0] rs1_idx,
	output logic [pipe_pkg::REG_IDX_W-1:0] rs2_idx,
	output logic [pipe_pkg::XLEN-1:0]      rs1_data,
	output logic [pipe_pkg::XLEN-1:0]      rs2_data,
	output logic [pipe_pkg::REG_IDX_W-1:0] dest_idx,
	output logic                           halt,
	output logic                           illegal
);

	pipe_pkg::inst_word_t           word;
	logic                           accept;
	logic                           stop;         // halt or illegal being accepted
	logic                           halt_lock;
	logic [2:0]                     f3_op;
	logic                           f3_ok;
	logic [2:0]                     op_next;
	logic                           use_imm_next;
	logic                           halt_next;
	logic                           illegal_next;
	logic [pipe_pkg::REG_IDX_W-1:0] rs2_next;
	logic [pipe_pkg::REG_IDX_W-1:0] dest_next;
	logic [pipe_pkg::XLEN-1:0]      imm_next;
	logic [pipe_pkg::XLEN-1:0]      rs1_rd;
	logic [pipe_pkg::XLEN-1:0]      rs2_rd;

	assign word   = inst;
	assign accept = inst_valid && inst_ready;
	assign stop   = halt_next || illegal_next;
	assign imm_next = {{(pipe_pkg::XLEN-12){word.i.imm[11]}}, word.i.imm};

	////////////////////////////////////////
	// field decode
	////////////////////////////////////////

	// funct3 sits in the same slot for both views
	always_comb begin
		f3_ok = 1'b1;
		case (word.i.funct3)
			pipe_pkg::F3_ADD_SUB: f3_op = pipe_pkg::ALU_ADD;
			pipe_pkg::F3_SLT:     f3_op = pipe_pkg::ALU_SLT;
			pipe_pkg::F3_XOR:     f3_op = pipe_pkg::ALU_XOR;
			pipe_pkg::F3_OR:      f3_op = pipe_pkg::ALU_OR;
			pipe_pkg::F3_AND:     f3_op = pipe_pkg::ALU_AND;
			default: begin
				f3_op = pipe_pkg::ALU_ADD;
				f3_ok = 1'b0;  // shifts, sltu
			end
		endcase
	end

	always_comb begin
		op_next      = f3_op;
		use_imm_next = 1'b0;
		halt_next    = 1'b0;
		illegal_next = 1'b0;
		rs2_next     = word.r.rs2;
		dest_next    = word.r.rd;
		case (word.r.opcode)
			pipe_pkg::OPC_OP: begin
				if (word.r.funct3 == pipe_pkg::F3_ADD_SUB && word.r.funct7 == pipe_pkg::F7_SUB)
					op_next = pipe_pkg::ALU_SUB;
				else if (!f3_ok || word.r.funct7 != '0)
					illegal_next = 1'b1;
			end
			pipe_pkg::OPC_OP_IMM: begin
				use_imm_next = 1'b1;
				rs2_next     = pipe_pkg::ZERO_REG;  // no second source
				illegal_next = !f3_ok;
			end
			pipe_pkg::OPC_SYSTEM: begin
				halt_next    = (inst == pipe_pkg::INST_WFI);
				illegal_next = (inst != pipe_pkg::INST_WFI);
			end
			default: illegal_next = 1'b1;
		endcase
		if (stop)
			dest_next = pipe_pkg::ZERO_REG;  // nothing to forward or write
	end

	reg_file u_reg_file (
		.clock(clock), .reset(reset),
		.rs1_idx(word.r.rs1), .rs2_idx(rs2_next),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.rs1_data(rs1_rd), .rs2_data(rs2_rd)
	);

	////////////////////////////////////////
	// handshake and decode register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset) begin
			dec_valid  <= 1'b0;
			halt_lock  <= 1'b0;
			inst_ready <= 1'b0;
		end else begin
			dec_valid <= accept;
			if (accept && stop)
				halt_lock <= 1'b1;  // held until reset
			inst_ready <= !(halt_lock || (accept && stop));
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			dec_pc   <= inst_pc;
			alu_op   <= op_next;
			use_imm  <= use_imm_next;
			imm      <= imm_next;
			rs1_idx  <= word.r.rs1;
			rs2_idx  <= rs2_next;
			rs1_data <= rs1_rd;
			rs2_data <= rs2_rd;
			dest_idx <= dest_next;
			halt     <= halt_next;
			illegal  <= illegal_next;
		end
	end

	// once a stopping word is taken the source stays shut out
	a_ready_locked: assert property (@(posedge clock) disable iff (!reset)
		accept && stop |=> always !inst_ready);

endmodule

// ==== design/execute_stage.sv ====
// execute stage
// operand forwarding, ALU and the execute-to-result register

`timescale 1ns/1ps

module execute_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           dec_valid,
	input  logic [pipe_pkg::XLEN-1:0]      dec_pc,
	input  logic [2:0]                     alu_op,
	input  logic                           use_imm,
	input  logic [pipe_pkg::XLEN-1:0]      imm,
	input  logic [pipe_pkg::REG_IDX_W-1:0] rs1_idx,
	input  logic [pipe_pkg::REG_IDX_W-1:0] rs2_idx,
	input  logic [pipe_pkg::XLEN-1:0]      rs1_data,
	input  logic [pipe_pkg::XLEN-1:0]      rs2_data,
	input  logic [pipe_pkg::REG_IDX_W-1:0] dest_idx,
	input  logic                           halt,
	input  logic                           illegal,
	input  logic                           wr_en,
	input  logic [pipe_pkg::REG_IDX_W-1:0] wr_idx,
	input  logic [pipe_pkg::XLEN-1:0]      wr_data,
	output logic                           res_valid,
	output logic [pipe_pkg::XLEN-1:0]      res_pc,
	output logic [pipe_pkg::XLEN-1:0]      res_data,
	output logic [pipe_pkg::REG_IDX_W-1:0] res_dest,
	output logic                           res_halt,
	output logic                           res_illegal
);

	logic [pipe_pkg::XLEN-1:0] op_a;
	logic [pipe_pkg::XLEN-1:0] rs2_val;
	logic [pipe_pkg::XLEN-1:0] op_b;
	logic [pipe_pkg::XLEN-1:0] alu_out;

	////////////////////////////////////////
	// forwarding
	////////////////////////////////////////

	// youngest producer wins: execute output, then commit, then decode read
	function automatic logic [pipe_pkg::XLEN-1:0] pick_operand(
		input logic [pipe_pkg::REG_IDX_W-1:0] idx,
		input logic [pipe_pkg::XLEN-1:0]      dec_val
	);
		if (res_valid && res_dest == idx && idx != pipe_pkg::ZERO_REG)
			return res_data;
		else if (wr_en && wr_idx == idx)
			return wr_data;  // wr_en never set for x0
		return dec_val;
	endfunction

	always_comb begin
		op_a    = pick_operand(rs1_idx, rs1_data);
		rs2_val = pick_operand(rs2_idx, rs2_data);
		op_b    = use_imm ? imm : rs2_val;
	end

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		case (alu_op)
			pipe_pkg::ALU_ADD: alu_out = op_a + op_b;
			pipe_pkg::ALU_SUB: alu_out = op_a - op_b;
			pipe_pkg::ALU_SLT: alu_out = {{(pipe_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			pipe_pkg::ALU_XOR: alu_out = op_a ^ op_b;
			pipe_pkg::ALU_OR:  alu_out = op_a | op_b;
			pipe_pkg::ALU_AND: alu_out = op_a & op_b;
			default:           alu_out = '0;  // unused codes
		endcase
	end

	// result register, tags ride along with the data
	always_ff @(posedge clock) begin
		if (!reset)
			res_valid <= 1'b0;
		else
			res_valid <= dec_valid;
	end

	always_ff @(posedge clock) begin
		res_pc      <= dec_pc;
		res_data    <= alu_out;
		res_dest    <= dest_idx;
		res_halt    <= halt;
		res_illegal <= illegal;
	end

	// pipeline comes out of reset empty
	a_empty_after_reset: assert property (@(posedge clock) $rose(reset) |=> !res_valid);

endmodule

// ==== design/result_stage.sv ====
// result stage
// commit register, register file write port and sticky error status

`timescale 1ns/1ps

module result_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           res_valid,
	input  logic [pipe_pkg::XLEN-1:0]      res_pc,
	input  logic [pipe_pkg::XLEN-1:0]      res_data,
	input  logic [pipe_pkg::REG_IDX_W-1:0] res_dest,
	input  logic                           res_halt,
	input  logic                           res_illegal,
	output logic                           commit_valid,
	output logic [pipe_pkg::XLEN-1:0]      commit_pc,
	output logic                           commit_wr_en,
	output logic [pipe_pkg::REG_IDX_W-1:0] commit_wr_idx,
	output logic [pipe_pkg::XLEN-1:0]      commit_wr_data,
	output logic [1:0]                     error_status
);

	logic writes;  // instruction that updates a register

	assign writes = res_valid && (res_dest != pipe_pkg::ZERO_REG) && !res_halt && !res_illegal;

	////////////////////////////////////////
	// commit register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset) begin
			commit_valid <= 1'b0;
			commit_wr_en <= 1'b0;
		end else begin
			commit_valid <= res_valid;
			commit_wr_en <= writes;
		end
	end

	always_ff @(posedge clock) begin
		commit_pc      <= res_pc;
		commit_wr_idx  <= res_dest;
		commit_wr_data <= res_data;
	end

	// first stopping instruction sets the code, later ones leave it
	always_ff @(posedge clock) begin
		if (!reset) begin
			error_status <= pipe_pkg::ERR_NONE;
		end else if (error_status == pipe_pkg::ERR_NONE && res_valid) begin
			if (res_illegal)
				error_status <= pipe_pkg::ERR_ILLEGAL;
			else if (res_halt)
				error_status <= pipe_pkg::ERR_HALTED;
		end
	end

	// a write only ever goes out with its commit, and never to x0
	a_write_qualified: assert property (@(posedge clock) disable iff (!reset)
		commit_wr_en |-> commit_valid && commit_wr_idx != pipe_pkg::ZERO_REG);

endmodule

// ==== design/pipeline_top.sv ====
// three stage integer pipeline
// decode, execute and result stages with the commit port at the top

`timescale 1ns/1ps

module pipeline_top (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          inst_valid,
	input  logic [pipe_pkg::XLEN-1:0]     inst,
	input  logic [pipe_pkg::XLEN-1:0]     inst_pc,
	output logic                          inst_ready,
	output logic                          commit_valid,
	output logic [pipe_pkg::XLEN-1:0]     commit_pc,
	output logic                          commit_wr_en,
	output logic [pipe_pkg::REG_IDX_W-1:0] commit_wr_idx,
	output logic [pipe_pkg::XLEN-1:0]     commit_wr_data,
	output logic [1:0]                    error_status
);

	// decode register
	logic                           dec_valid;
	logic [pipe_pkg::XLEN-1:0]      dec_pc;
	logic [2:0]                     alu_op;
	logic                           use_imm;
	logic [pipe_pkg::XLEN-1:0]      imm;
	logic [pipe_pkg::REG_IDX_W-1:0] rs1_idx;
	logic [pipe_pkg::REG_IDX_W-1:0] rs2_idx;
	logic [pipe_pkg::XLEN-1:0]      rs1_data;
	logic [pipe_pkg::XLEN-1:0]      rs2_data;
	logic [pipe_pkg::REG_IDX_W-1:0] dest_idx;
	logic                           halt;
	logic                           illegal;

	// execute register
	logic                           res_valid;
	logic [pipe_pkg::XLEN-1:0]      res_pc;
	logic [pipe_pkg::XLEN-1:0]      res_data;
	logic [pipe_pkg::REG_IDX_W-1:0] res_dest;
	logic                           res_halt;
	logic                           res_illegal;

	decode_stage u_decode (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
		.wr_en(commit_wr_en), .wr_idx(commit_wr_idx), .wr_data(commit_wr_data),
		.inst_ready(inst_ready), .dec_valid(dec_valid), .dec_pc(dec_pc),
		.alu_op(alu_op), .use_imm(use_imm), .imm(imm),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.dest_idx(dest_idx), .halt(halt), .illegal(illegal)
	);

	execute_stage u_execute (
		.clock(clock), .reset(reset),
		.dec_valid(dec_valid), .dec_pc(dec_pc), .alu_op(alu_op),
		.use_imm(use_imm), .imm(imm), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .dest_idx(dest_idx),
		.halt(halt), .illegal(illegal),
		.wr_en(commit_wr_en), .wr_idx(commit_wr_idx), .wr_data(commit_wr_data),
		.res_valid(res_valid), .res_pc(res_pc), .res_data(res_data),
		.res_dest(res_dest), .res_halt(res_halt), .res_illegal(res_illegal)
	);

	result_stage u_result (
		.clock(clock), .reset(reset),
		.res_valid(res_valid), .res_pc(res_pc), .res_data(res_data),
		.res_dest(res_dest), .res_halt(res_halt), .res_illegal(res_illegal),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_wr_en(commit_wr_en),
		.commit_wr_idx(commit_wr_idx), .commit_wr_data(commit_wr_data),
		.error_status(error_status)
	);

endmodule

// ==== tests/ref_model.svh ====
// reference model for the pipeline testbench
// decodes each accepted word and predicts its commit from a model register file

`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0] model_regs [32];
logic [1:0]  model_status;

function automatic void reset_model();
	for (int n = 0; n < 32; n++)
		model_regs[n] = '0;
	model_status = pipe_pkg::ERR_NONE;
endfunction

// steps the model by one instruction, in program order
function automatic void predict_commit(
	input  logic [31:0] word,
	output logic        wr_en,
	output logic [4:0]  idx,
	output logic [31:0] data,
	output logic        stop,
	output logic [1:0]  status
);
	logic [6:0]  opcode;
	logic [2:0]  f3;
	logic [31:0] a;
	logic [31:0] b;
	logic        legal;
	logic        is_sub;

	opcode = word[6:0];
	f3     = word[14:12];
	idx    = word[11:7];
	a      = model_regs[word[19:15]];  // x0 is never written, stays zero
	is_sub = (opcode == pipe_pkg::OPC_OP) && (word[31:25] == pipe_pkg::F7_SUB) && (f3 == 3'b000);
	legal  = (f3 != 3'b001) && (f3 != 3'b011) && (f3 != 3'b101);  // shifts and sltu
	if (opcode == pipe_pkg::OPC_OP) begin
		b     = model_regs[word[24:20]];
		legal = legal && (word[31:25] == 7'd0 || is_sub);
	end else begin
		b     = {{20{word[31]}}, word[31:20]};
		legal = legal && (opcode == pipe_pkg::OPC_OP_IMM);  // WFI lands here too
	end

	case (f3)
		3'b000:  data = is_sub ? a - b : a + b;
		3'b010:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100:  data = a ^ b;
		3'b110:  data = a | b;
		default: data = a & b;
	endcase

	stop  = !legal;
	wr_en = legal && (idx != 5'd0);
	if (wr_en)
		model_regs[idx] = data;

	// first stopping word decides the status
	if (stop && model_status == pipe_pkg::ERR_NONE)
		model_status = (word == pipe_pkg::INST_WFI) ? pipe_pkg::ERR_HALTED : pipe_pkg::ERR_ILLEGAL;
	status = model_status;
endfunction

`endif

// ==== tests/pipeline_tb.sv ====
// testbench for the three stage pipeline
// drives instructions through the input handshake and checks every commit

`timescale 1ns/1ps

module pipeline_tb;

	localparam int RESET_CYCLES = 10;
	localparam int NUM_LOAD     = 15;
	localparam int NUM_INDEP    = 40;
	localparam int CHAIN_LEN    = 12;
	localparam int NUM_GAPPED   = 40;
	localparam int MAX_GAP      = 3;
	localparam int OFFER_CYCLES = 4;
	localparam int DRAIN_IDLE   = 4;
	// every instruction, then every idle cycle the sequence can spend
	localparam int NUM_INSTS = NUM_LOAD + NUM_INDEP + 3 * CHAIN_LEN + 4 + NUM_GAPPED + 1 + 4 + 1;
	localparam int IDLE_CYCLES = 2 * (RESET_CYCLES + 1) + NUM_GAPPED * MAX_GAP
		+ 6 * OFFER_CYCLES + 8 * (DRAIN_IDLE + 3);
	localparam int CYCLE_LIMIT = NUM_INSTS + IDLE_CYCLES + 50;

	logic        clock;
	logic        reset;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic        inst_ready;
	logic        commit_valid;
	logic [31:0] commit_pc;
	logic        commit_wr_en;
	logic [4:0]  commit_wr_idx;
	logic [31:0] commit_wr_data;
	logic [1:0]  error_status;

	integer      seed;
	int          cycle_count = 0;
	int          checks;
	int          errors;
	logic [31:0] next_pc;

	// expected commits, oldest first
	logic [31:0] exp_pc_q [$];
	int          exp_cycle_q [$];
	logic        exp_wr_en_q [$];
	logic [4:0]  exp_idx_q [$];
	logic [31:0] exp_data_q [$];
	logic        exp_stop_q [$];
	logic [1:0]  exp_status_q [$];

	`include "ref_model.svh"

	pipeline_top DUT (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .inst_ready(inst_ready),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_wr_en(commit_wr_en),
		.commit_wr_idx(commit_wr_idx), .commit_wr_data(commit_wr_data),
		.error_status(error_status)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the pipeline did not finish", cycle_count);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// encoding and random helpers
	////////////////////////////////////////

	function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, pipe_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, pipe_pkg::OPC_OP_IMM};
	endfunction

	task automatic random_range(input int lo, input int hi, output int val);
		logic [31:0] r;
		r   = $random(seed);
		val = lo + int'(r % (hi - lo + 1));
	endtask

	// one of the eleven supported ALU forms
	task automatic random_op(input int rd, input int rs1, input int rs2, output logic [31:0] word);
		logic [2:0]  f3_table [5];
		logic [31:0] r;
		int          sel;
		f3_table = '{pipe_pkg::F3_ADD_SUB, pipe_pkg::F3_SLT, pipe_pkg::F3_XOR,
			pipe_pkg::F3_OR, pipe_pkg::F3_AND};
		r   = $random(seed);
		sel = int'(r % 11);
		if (sel == 5)
			word = rtype_word(pipe_pkg::F7_SUB, 5'(rs2), 5'(rs1), pipe_pkg::F3_ADD_SUB, 5'(rd));
		else if (sel < 5)
			word = rtype_word(7'd0, 5'(rs2), 5'(rs1), f3_table[sel], 5'(rd));
		else
			word = itype_word(r[31:20], 5'(rs1), f3_table[sel-6], 5'(rd));
	endtask

	////////////////////////////////////////
	// source side
	////////////////////////////////////////

	task automatic send_inst(input logic [31:0] word, input int gap);
		int          g;
		logic        wr_en;
		logic [4:0]  idx;
		logic [31:0] data;
		logic        stop;
		logic [1:0]  status;
		for (g = 0; g < gap; g++) begin
			inst_valid = 1'b0;
			inst       = $random(seed);  // junk while idle
			@(negedge clock);
		end
		inst_valid = 1'b1;
		inst       = word;
		inst_pc    = next_pc;
		while (!inst_ready)
			@(negedge clock);
		// ready holds until the next edge, so the transfer happens there
		predict_commit(word, wr_en, idx, data, stop, status);
		exp_pc_q.push_back(next_pc);
		exp_cycle_q.push_back(cycle_count + 3);
		exp_wr_en_q.push_back(wr_en);
		exp_idx_q.push_back(idx);
		exp_data_q.push_back(data);
		exp_stop_q.push_back(stop);
		exp_status_q.push_back(status);
		next_pc = next_pc + 32'd4;
		@(negedge clock);
		inst_valid = 1'b0;
	endtask

	// offers a word that must never be taken
	task automatic offer_blocked(input logic [31:0] word);
		int n;
		inst_valid = 1'b1;
		inst       = word;
		inst_pc    = next_pc;
		for (n = 0; n < OFFER_CYCLES; n++) begin
			checks++;
			if (inst_ready !== 1'b0) begin
				$display("[FAIL] inst_ready: got %h expected 0 at pc %h", inst_ready, next_pc);
				errors++;
			end
			@(negedge clock);
		end
		inst_valid = 1'b0;
		next_pc    = next_pc + 32'd4;
	endtask

	task automatic drain_pipeline();
		while (exp_pc_q.size() != 0)
			@(negedge clock);
		repeat (DRAIN_IDLE) @(negedge clock);  // room for stray commits
	endtask

	task automatic check_quiet(input logic with_ready);
		checks++;
		if (with_ready && inst_ready !== 1'b0) begin
			$display("[FAIL] inst_ready: got %h expected 0", inst_ready);
			errors++;
		end
		if (commit_valid !== 1'b0) begin
			$display("[FAIL] commit_valid: got %h expected 0", commit_valid);
			errors++;
		end
		if (commit_wr_en !== 1'b0) begin
			$display("[FAIL] commit_wr_en: got %h expected 0", commit_wr_en);
			errors++;
		end
		if (error_status !== pipe_pkg::ERR_NONE) begin
			$display("[FAIL] error_status: got %h expected %h", error_status, pipe_pkg::ERR_NONE);
			errors++;
		end
	endtask

	task automatic apply_reset();
		int n;
		reset      = 1'b0;
		inst_valid = 1'b0;
		reset_model();
		for (n = 0; n < RESET_CYCLES; n++) begin
			@(negedge clock);
			check_quiet(1'b1);
		end
		reset = 1'b1;
		@(negedge clock);
		check_quiet(1'b0);  // ready may rise on the release edge
	endtask

	task automatic check_stopped(input logic [1:0] code);
		checks++;
		if (error_status !== code) begin
			$display("[FAIL] error_status: got %h expected %h", error_status, code);
			errors++;
		end
		if (inst_ready !== 1'b0) begin
			$display("[FAIL] inst_ready: got %h expected 0", inst_ready);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// commit comparison
	////////////////////////////////////////

	task automatic check_commit();
		logic [31:0] pc;
		int          due;
		logic        stop;
		pc   = exp_pc_q.pop_front();
		due  = exp_cycle_q.pop_front();
		stop = exp_stop_q.pop_front();
		checks++;
		if (cycle_count != due) begin
			$display("commit for pc %h came at cycle %0d instead of %0d", pc, cycle_count, due);
			errors++;
		end
		if (commit_pc !== pc) begin
			$display("[FAIL] commit_pc: got %h expected %h", commit_pc, pc);
			errors++;
		end
		if (commit_wr_en !== exp_wr_en_q[0]) begin
			$display("[FAIL] commit_wr_en: got %h expected %h", commit_wr_en, exp_wr_en_q[0]);
			errors++;
		end
		if (!stop && commit_wr_idx !== exp_idx_q[0]) begin
			$display("[FAIL] commit_wr_idx: got %h expected %h", commit_wr_idx, exp_idx_q[0]);
			errors++;
		end
		if (!stop && commit_wr_data !== exp_data_q[0]) begin
			$display("[FAIL] commit_wr_data: got %h expected %h", commit_wr_data, exp_data_q[0]);
			errors++;
		end
		if (error_status !== exp_status_q[0]) begin
			$display("[FAIL] error_status: got %h expected %h", error_status, exp_status_q[0]);
			errors++;
		end
		void'(exp_wr_en_q.pop_front());
		void'(exp_idx_q.pop_front());
		void'(exp_data_q.pop_front());
		void'(exp_status_q.pop_front());
	endtask

	// commit outputs are settled by the falling edge
	always @(negedge clock) begin
		if (reset && commit_valid) begin
			if (exp_pc_q.size() == 0) begin
				$display("unexpected commit at pc %h with nothing outstanding", commit_pc);
				errors++;
			end else begin
				check_commit();
			end
		end else if (reset && exp_cycle_q.size() != 0 && cycle_count > exp_cycle_q[0]) begin
			$display("no commit seen for pc %h by cycle %0d", exp_pc_q[0], exp_cycle_q[0]);
			errors++;
			void'(exp_pc_q.pop_front());
			void'(exp_cycle_q.pop_front());
			void'(exp_wr_en_q.pop_front());
			void'(exp_idx_q.pop_front());
			void'(exp_data_q.pop_front());
			void'(exp_stop_q.pop_front());
			void'(exp_status_q.pop_front());
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] w;
		int          rd;
		int          rs1;
		int          rs2;
		int          gap;
		int          d;
		int          k;

		seed       = 32'h3816f135;
		reset      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		inst_pc    = '0;
		checks     = 0;
		errors     = 0;
		next_pc    = 32'h0000_1000;
		apply_reset();

		// x1..x15 get random immediates
		for (k = 1; k <= NUM_LOAD; k++) begin
			w = $random(seed);
			send_inst(itype_word(w[11:0], pipe_pkg::ZERO_REG, pipe_pkg::F3_ADD_SUB, 5'(k)), 0);
		end
		for (k = 0; k < NUM_INDEP; k++) begin
			random_range(16, 31, rd);  // sources never written here
			random_range(1, 15, rs1);
			random_range(1, 15, rs2);
			random_op(rd, rs1, rs2, w);
			send_inst(w, 0);
		end
		drain_pipeline();

		// each link reads the one d places back
		for (d = 1; d <= 3; d++) begin
			for (k = 0; k < CHAIN_LEN; k++) begin
				rd = 20 + k % d;
				random_range(1, 15, rs2);
				random_op(rd, rd, rs2, w);
				send_inst(w, 0);
			end
			drain_pipeline();
		end

		w = $random(seed);
		send_inst(itype_word(w[11:0], 5'd5, pipe_pkg::F3_ADD_SUB, pipe_pkg::ZERO_REG), 0);
		send_inst(rtype_word(7'd0, 5'd7, 5'd6, pipe_pkg::F3_ADD_SUB, pipe_pkg::ZERO_REG), 0);
		send_inst(rtype_word(7'd0, 5'd3, pipe_pkg::ZERO_REG, pipe_pkg::F3_ADD_SUB, 5'd21), 0);
		send_inst(rtype_word(7'd0, pipe_pkg::ZERO_REG, pipe_pkg::ZERO_REG, pipe_pkg::F3_OR, 5'd22), 0);
		drain_pipeline();

		// idle gaps with free dependencies
		for (k = 0; k < NUM_GAPPED; k++) begin
			random_range(1, 31, rd);
			random_range(0, 31, rs1);
			random_range(0, 31, rs2);
			random_range(0, MAX_GAP, gap);
			random_op(rd, rs1, rs2, w);
			send_inst(w, gap);
		end

		send_inst(pipe_pkg::INST_WFI, 0);
		for (k = 0; k < 3; k++) begin
			random_op(1, 2, 3, w);
			offer_blocked(w);
		end
		drain_pipeline();
		check_stopped(pipe_pkg::ERR_HALTED);

		// fresh start, then an SLL word
		apply_reset();
		for (k = 1; k <= 4; k++) begin
			w = $random(seed);
			send_inst(itype_word(w[11:0], pipe_pkg::ZERO_REG, pipe_pkg::F3_ADD_SUB, 5'(k)), 0);
		end
		send_inst(rtype_word(7'd0, 5'd2, 5'd1, 3'b001, 5'd3), 0);
		for (k = 0; k < 3; k++) begin
			random_op(5, 1, 2, w);
			offer_blocked(w);
		end
		drain_pipeline();
		check_stopped(pipe_pkg::ERR_ILLEGAL);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+tests
common/pipe_pkg.sv
design/decode/reg_file.sv
design/decode/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/pipeline_top.sv
tests/pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: pipeline

sources:
  - common/pipe_pkg.sv
  - design/decode/reg_file.sv
  - design/decode/decode_stage.sv
  - design/execute_stage.sv
  - design/result_stage.sv
  - design/pipeline_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pipeline_tb.sv
